//--- rv_core_pkg.sv
// ====================
// rv_core shared definitions
// widths, opcode and alu enums, funct3/funct7 values
// ====================
`default_nettype none

package rv_core_pkg;

  // data and address width
  parameter int xlen = 32;
  // register index width, 32 architectural registers
  parameter int reg_idx_w = 5;

  // instruction field widths
  parameter int opcode_w = 7;
  parameter int funct3_w = 3;
  parameter int funct7_w = 7;

  // major opcodes of the kept rv32i subset
  typedef enum logic [opcode_w-1:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_system = 7'b1110011
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link
  } wb_sel_e;

  // branch and memory funct3
  parameter logic [funct3_w-1:0] f3_beq  = 3'b000;
  parameter logic [funct3_w-1:0] f3_bne  = 3'b001;
  parameter logic [funct3_w-1:0] f3_word = 3'b010;
  parameter logic [funct3_w-1:0] f3_jalr = 3'b000;

  // alu funct3, op_reg and op_imm share the encoding
  parameter logic [funct3_w-1:0] f3_add = 3'b000;
  parameter logic [funct3_w-1:0] f3_sll = 3'b001;
  parameter logic [funct3_w-1:0] f3_slt = 3'b010;
  parameter logic [funct3_w-1:0] f3_xor = 3'b100;
  parameter logic [funct3_w-1:0] f3_srl = 3'b101;
  parameter logic [funct3_w-1:0] f3_or  = 3'b110;
  parameter logic [funct3_w-1:0] f3_and = 3'b111;

  // funct7, alt selects sub
  parameter logic [funct7_w-1:0] f7_base = 7'b0000000;
  parameter logic [funct7_w-1:0] f7_alt  = 7'b0100000;

  // full ebreak word
  parameter logic [xlen-1:0] ebreak_word = 32'h0010_0073;

endpackage

`default_nettype wire

//--- inst_decoder.sv
// ====================
// rv_core instruction decoder
// field split, immediate build and control for the rv32i subset
// ====================
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  wire  [rv_core_pkg::xlen-1:0]      inst,
  output logic [rv_core_pkg::reg_idx_w-1:0] rs1,
  output logic [rv_core_pkg::reg_idx_w-1:0] rs2,
  output logic [rv_core_pkg::reg_idx_w-1:0] rd,
  output logic [rv_core_pkg::xlen-1:0]      imm,
  output rv_core_pkg::alu_op_e              alu_op,
  output rv_core_pkg::wb_sel_e              wb_sel,
  output logic                              use_imm,
  output logic                              use_pc,
  output logic                              reg_wen,
  output logic                              mem_wen,
  output logic                              is_jal,
  output logic                              is_jalr,
  output logic                              is_branch,
  output logic                              branch_ne,
  output logic                              is_ebreak,
  output logic                              is_illegal
);

  import rv_core_pkg::*;

  opcode_e             opcode;
  logic [funct3_w-1:0] funct3;
  logic [funct7_w-1:0] funct7;
  logic [xlen-1:0]     imm_i;
  logic [xlen-1:0]     imm_s;
  logic [xlen-1:0]     imm_b;
  logic [xlen-1:0]     imm_u;
  logic [xlen-1:0]     imm_j;
  // enables before the illegal gate
  logic                reg_wen_dec;
  logic                mem_wen_dec;

  // fixed field positions
  assign opcode = opcode_e'(inst[opcode_w-1:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // immediates, sign taken from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm         = '0;
    alu_op      = alu_add;
    wb_sel      = wb_alu;
    use_imm     = 1'b0;
    use_pc      = 1'b0;
    reg_wen_dec = 1'b0;
    mem_wen_dec = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_branch   = 1'b0;
    branch_ne   = 1'b0;
    is_ebreak   = 1'b0;
    is_illegal  = 1'b0;
    case (opcode)
      op_reg: begin
        reg_wen_dec = 1'b1;
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add:  alu_op = alu_add;
            f3_sll:  alu_op = alu_sll;
            f3_slt:  alu_op = alu_slt;
            f3_xor:  alu_op = alu_xor;
            f3_srl:  alu_op = alu_srl;
            f3_or:   alu_op = alu_or;
            f3_and:  alu_op = alu_and;
            default: is_illegal = 1'b1;
          endcase
        end else if (funct7 == f7_alt && funct3 == f3_add) begin
          alu_op = alu_sub;
        end else begin
          is_illegal = 1'b1;
        end
      end
      op_imm: begin
        // only addi is kept
        imm         = imm_i;
        use_imm     = 1'b1;
        reg_wen_dec = 1'b1;
        is_illegal  = (funct3 != f3_add);
      end
      op_lui: begin
        imm         = imm_u;
        use_imm     = 1'b1;
        alu_op      = alu_pass_b;
        reg_wen_dec = 1'b1;
      end
      op_auipc: begin
        imm         = imm_u;
        use_imm     = 1'b1;
        use_pc      = 1'b1;
        reg_wen_dec = 1'b1;
      end
      op_load: begin
        // word loads only
        imm         = imm_i;
        use_imm     = 1'b1;
        wb_sel      = wb_mem;
        reg_wen_dec = 1'b1;
        is_illegal  = (funct3 != f3_word);
      end
      op_store: begin
        imm         = imm_s;
        use_imm     = 1'b1;
        mem_wen_dec = 1'b1;
        is_illegal  = (funct3 != f3_word);
      end
      op_jal: begin
        imm         = imm_j;
        is_jal      = 1'b1;
        wb_sel      = wb_link;
        reg_wen_dec = 1'b1;
      end
      op_jalr: begin
        // target comes from the alu sum rs1 + imm
        imm         = imm_i;
        use_imm     = 1'b1;
        is_jalr     = 1'b1;
        wb_sel      = wb_link;
        reg_wen_dec = 1'b1;
        is_illegal  = (funct3 != f3_jalr);
      end
      op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          f3_beq:  branch_ne = 1'b0;
          f3_bne:  branch_ne = 1'b1;
          default: is_illegal = 1'b1;
        endcase
      end
      op_system: begin
        // ebreak is the only system word decoded
        is_ebreak  = (inst == ebreak_word);
        is_illegal = (inst != ebreak_word);
      end
      default: is_illegal = 1'b1;
    endcase
  end

  // illegal words never write state
  assign reg_wen = reg_wen_dec & ~is_illegal;
  assign mem_wen = mem_wen_dec & ~is_illegal;

endmodule

`default_nettype wire

//--- reg_file.sv
// ====================
// rv_core register file
// 31 registers, two async reads, one write, x0 tied to zero
// ====================
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire  [rv_core_pkg::reg_idx_w-1:0] rs1,
  input  wire  [rv_core_pkg::reg_idx_w-1:0] rs2,
  input  wire  [rv_core_pkg::reg_idx_w-1:0] rd,
  input  wire                               wen,
  input  wire  [rv_core_pkg::xlen-1:0]      wdata,
  output logic [rv_core_pkg::xlen-1:0]      rdata_1,
  output logic [rv_core_pkg::xlen-1:0]      rdata_2
);

  import rv_core_pkg::*;

  localparam int num_regs = 2 ** reg_idx_w;

  // x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // reads see the old value during a write cycle
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- exec_unit.sv
// ====================
// rv_core execute unit
// alu, branch and next pc, writeback select, pc and halt flags
// ====================
`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
  parameter logic [rv_core_pkg::xlen-1:0] pc_reset = 32'h0000_0000
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  [rv_core_pkg::xlen-1:0] imm,
  input  rv_core_pkg::alu_op_e         alu_op,
  input  rv_core_pkg::wb_sel_e         wb_sel,
  input  wire                          use_imm,
  input  wire                          use_pc,
  input  wire                          reg_wen,
  input  wire                          mem_wen,
  input  wire                          is_jal,
  input  wire                          is_jalr,
  input  wire                          is_branch,
  input  wire                          branch_ne,
  input  wire                          is_ebreak,
  input  wire                          is_illegal,
  input  wire  [rv_core_pkg::xlen-1:0] rdata_1,
  input  wire  [rv_core_pkg::xlen-1:0] rdata_2,
  input  wire  [rv_core_pkg::xlen-1:0] dmem_rdata,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] wb_data,
  output logic                         wb_en,
  output logic [rv_core_pkg::xlen-1:0] dmem_addr,
  output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
  output logic                         dmem_wen,
  output logic                         halted,
  output logic                         illegal
);

  import rv_core_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] next_pc;
  logic            br_taken;
  // current word stops the core, or it is already stopped
  logic            stop;

  // operand a is the pc only for auipc
  assign op_a = use_pc ? pc : rdata_1;
  assign op_b = use_imm ? imm : rdata_2;

  always_comb begin
    case (alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_or:     alu_res = op_a | op_b;
      alu_xor:    alu_res = op_a ^ op_b;
      // signed compare, result is 0 or 1
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      // shift amount is the low 5 bits
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_pass_b: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // beq taken on equal, bne on not equal
  assign br_taken = is_branch & ((rdata_1 == rdata_2) ^ branch_ne);

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    if (is_jal) begin
      next_pc = pc_target;
    end else if (is_jalr) begin
      next_pc = {alu_res[xlen-1:1], 1'b0};
    end else if (br_taken) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    case (wb_sel)
      wb_mem:  wb_data = dmem_rdata;
      wb_link: wb_data = pc_plus4;
      default: wb_data = alu_res;
    endcase
  end

  assign stop = is_ebreak | is_illegal | halted | illegal;

  // state updates suppressed once stopped
  assign wb_en      = reg_wen & ~stop;
  assign dmem_wen   = mem_wen & ~stop;
  assign dmem_addr  = alu_res;
  assign dmem_wdata = rdata_2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= pc_reset;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (!stop) begin
        pc <= next_pc;
      end
      // sticky, the frozen pc keeps the same word on the bus
      if (is_ebreak) begin
        halted <= 1'b1;
      end
      if (is_illegal) begin
        illegal <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rv_core.sv
// ====================
// rv_core top level
// single-cycle rv32i core with direct memory ports
// ====================
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter logic [rv_core_pkg::xlen-1:0] pc_reset = 32'h0000_0000
) (
  input  wire                          clk,
  input  wire                          rst_n,
  output logic [rv_core_pkg::xlen-1:0] imem_addr,
  input  wire  [rv_core_pkg::xlen-1:0] imem_rdata,
  output logic [rv_core_pkg::xlen-1:0] dmem_addr,
  output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
  output logic                         dmem_wen,
  input  wire  [rv_core_pkg::xlen-1:0] dmem_rdata,
  output logic                         halted,
  output logic                         illegal
);

  import rv_core_pkg::*;

  // decoder to register file
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic [reg_idx_w-1:0] rd;

  // decoder to execute unit
  logic [xlen-1:0] imm;
  alu_op_e         alu_op;
  wb_sel_e         wb_sel;
  logic            use_imm;
  logic            use_pc;
  logic            reg_wen;
  logic            mem_wen;
  logic            is_jal;
  logic            is_jalr;
  logic            is_branch;
  logic            branch_ne;
  logic            is_ebreak;
  logic            is_illegal;

  // register file and writeback
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] wb_data;
  logic            wb_en;

  // fetched word goes straight to the decoder
  inst_decoder i_inst_decoder (
    .inst(imem_rdata), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .wb_sel(wb_sel), .use_imm(use_imm), .use_pc(use_pc),
    .reg_wen(reg_wen), .mem_wen(mem_wen), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_branch(is_branch), .branch_ne(branch_ne), .is_ebreak(is_ebreak),
    .is_illegal(is_illegal)
  );

  reg_file i_reg_file (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wen(wb_en), .wdata(wb_data), .rdata_1(rdata_1), .rdata_2(rdata_2)
  );

  // pc from the execute unit drives the fetch address
  exec_unit #(.pc_reset(pc_reset)) i_exec_unit (
    .clk(clk), .rst_n(rst_n), .imm(imm), .alu_op(alu_op), .wb_sel(wb_sel),
    .use_imm(use_imm), .use_pc(use_pc), .reg_wen(reg_wen), .mem_wen(mem_wen),
    .is_jal(is_jal), .is_jalr(is_jalr), .is_branch(is_branch),
    .branch_ne(branch_ne), .is_ebreak(is_ebreak), .is_illegal(is_illegal),
    .rdata_1(rdata_1), .rdata_2(rdata_2), .dmem_rdata(dmem_rdata),
    .pc(imem_addr), .wb_data(wb_data), .wb_en(wb_en), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wen(dmem_wen), .halted(halted),
    .illegal(illegal)
  );

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
// ====================
// rv_core concurrent checks
// reset state, halt and illegal freeze, store alignment, pc flow
// ====================
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions #(
  parameter logic [rv_core_pkg::xlen-1:0] pc_reset = 32'h0000_0000
) (
  input wire                          clk,
  input wire                          rst_n,
  input wire [rv_core_pkg::xlen-1:0]  imem_addr,
  input wire [rv_core_pkg::xlen-1:0]  dmem_addr,
  input wire                          dmem_wen,
  input wire                          halted,
  input wire                          illegal,
  input wire                          is_jal,
  input wire                          is_jalr,
  input wire                          is_branch,
  input wire                          is_ebreak,
  input wire                          is_illegal
);

  // number of failed checks so far
  int   fail_count = 0;
  logic stop;

  // same stop condition as the execute unit
  assign stop = is_ebreak | is_illegal | halted | illegal;

  // first edge after release sees the reset pc
  reset_state: assert property (@(posedge clk)
      $rose(rst_n) |-> imem_addr == pc_reset && !dmem_wen && !halted && !illegal)
    else begin
      $error("core left reset with a wrong pc, a store or a flag set");
      fail_count++;
    end

  // word access only
  store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_wen |-> dmem_addr[1:0] == 2'b00)
    else begin
      $error("store address %h is not word aligned", dmem_addr);
      fail_count++;
    end

  // fetch address stays on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      imem_addr[1:0] == 2'b00)
    else begin
      $error("fetch address %h is not word aligned", imem_addr);
      fail_count++;
    end

  // straight-line code steps by one word
  pc_step: assert property (@(posedge clk) disable iff (!rst_n)
      !(is_jal || is_jalr || is_branch || stop) |=> imem_addr == $past(imem_addr) + 32'd4)
    else begin
      $error("pc did not advance by 4 on a plain instruction");
      fail_count++;
    end

  // ebreak sets halted one edge later with the pc held
  ebreak_halts: assert property (@(posedge clk) disable iff (!rst_n)
      (is_ebreak && !halted && !illegal) |=> halted && !illegal && $stable(imem_addr))
    else begin
      $error("ebreak did not raise halted with the pc frozen");
      fail_count++;
    end

  // illegal word stops the core through the other flag
  illegal_stops: assert property (@(posedge clk) disable iff (!rst_n)
      (is_illegal && !halted && !illegal) |=> illegal && !halted && $stable(imem_addr))
    else begin
      $error("illegal word did not raise illegal with the pc frozen");
      fail_count++;
    end

  // everything holds once stopped
  stopped_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      (halted || illegal) |=> $stable(imem_addr) && $stable(halted) && $stable(illegal))
    else begin
      $error("pc or flags moved after the core stopped");
      fail_count++;
    end

  // no store from a stopping or stopped core
  no_store_stopped: assert property (@(posedge clk) disable iff (!rst_n)
      stop |-> !dmem_wen)
    else begin
      $error("store strobe high while the core is stopping");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tb_rv_core.sv
// ====================
// rv_core testbench
// lfsr-built program, memory models, store table, halt and illegal runs
// ====================
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam logic [31:0] pc_start = 32'h0000_0100;
  // sw x0 to 0x7f0(x10) outside the table
  localparam logic [31:0] marker = {7'h3f, 5'd0, 5'd10, 3'b010, 5'h10, 7'h23};
  // {funct7, funct3} of add, sub, and, or, xor, slt, sll, srl
  localparam logic [9:0] r_ops [0:7] = '{
    {7'h00, 3'b000}, {7'h20, 3'b000}, {7'h00, 3'b111}, {7'h00, 3'b110},
    {7'h00, 3'b100}, {7'h00, 3'b010}, {7'h00, 3'b001}, {7'h00, 3'b101}
  };

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_wen;
  logic [31:0] dmem_rdata;
  logic        halted;
  logic        illegal;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:1023];
  // expected stores by byte address
  logic [31:0] exp_data [logic [31:0]];
  bit          seen [logic [31:0]];
  // register values the program should produce
  logic [31:0] model [0:31];
  logic [31:0] lfsr_state;
  logic [31:0] prog_pc;
  logic [11:0] store_off;
  int          missing;

  rv_core #(.pc_reset(pc_start)) i_rv_core (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wen(dmem_wen),
    .dmem_rdata(dmem_rdata), .halted(halted), .illegal(illegal)
  );

  bind rv_core rv_core_assertions #(.pc_reset(pc_reset)) i_rv_core_assertions (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
    .dmem_wen(dmem_wen), .halted(halted), .illegal(illegal), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_branch(is_branch), .is_ebreak(is_ebreak),
    .is_illegal(is_illegal)
  );

  // combinational reads and writes at the strobe edge
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      dmem[dmem_addr[11:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped on first error");
  endtask

  // each table store exactly once with the expected word
  always @(negedge clk) begin
    if (rst_n && dmem_wen) begin
      assert (exp_data.exists(dmem_addr) && !seen.exists(dmem_addr))
        else report_failure($sformatf("Mismatch at %0t: unexpected store of %h to %h",
                                      $time, dmem_wdata, dmem_addr));
      assert (exp_data[dmem_addr] === dmem_wdata)
        else report_failure($sformatf("Mismatch at %0t: store to %h is %h, expected %h",
                                      $time, dmem_addr, dmem_wdata, exp_data[dmem_addr]));
      seen[dmem_addr] = 1'b1;
    end
  end

  always @(negedge clk) begin
    assert (i_rv_core.i_rv_core_assertions.fail_count == 0)
      else report_failure("a concurrent check on rv_core failed");
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // rv32i encodings
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // register-register result by funct3 with funct7 bit 5 picking sub
  function automatic logic [31:0] r_ref(input logic [6:0] f7, input logic [2:0] f3,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return f7[5] ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void emit(input logic [31:0] word);
    imem[prog_pc[9:2]] = word;
    prog_pc = prog_pc + 32'd4;
  endfunction

  // x0 never changes
  function automatic void set_reg(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 5'd0) begin
      model[rd] = v;
    end
  endfunction

  // sw rs to the next free word above x10
  function automatic void store_reg(input logic [4:0] rs);
    emit(enc_s(store_off, rs, 5'd10));
    exp_data[model[10] + 32'(store_off)] = model[rs];
    store_off = store_off + 12'd4;
  endfunction

  // lui then addi builds a full random word
  function automatic void load_random(input logic [4:0] rd);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lfsr_bits(20);
    lo = lfsr_bits(12);
    emit(enc_u(hi[19:0], rd, 7'h37));
    emit(enc_i(lo[11:0], rd, 3'b000, rd, 7'h13));
    set_reg(rd, {hi[19:0], 12'h000} + sext12(lo[11:0]));
  endfunction

  // taken branch skips the marker and a not-taken one runs a real store
  function automatic void branch_case(input logic [2:0] f3, input logic [4:0] ra,
      input logic [4:0] rb);
    logic taken;
    if (f3 == 3'b000) begin
      taken = (model[ra] == model[rb]);
    end else begin
      taken = (model[ra] != model[rb]);
    end
    emit(enc_b(13'd8, rb, ra, f3));
    if (taken) begin
      emit(marker);
    end else begin
      store_reg(5'd1);
    end
  endfunction

  function automatic void clear_state();
    // unused words have opcode zero and decode as illegal
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'(i) << 9;
    end
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = 32'h5a00_0000 | (32'(i) << 2);
    end
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    exp_data.delete();
    seen.delete();
    prog_pc = pc_start;
    store_off = '0;
  endfunction

  function automatic void build_main();
    logic [31:0] pc_jump;
    logic [31:0] rnd;
    // x10 is the store base
    emit(enc_u(20'h00001, 5'd10, 7'h37));
    set_reg(5'd10, 32'h0000_1000);
    for (int r = 0; r < 2; r++) begin
      load_random(5'd1);
      load_random(5'd2);
      for (int k = 0; k < 8; k++) begin
        emit(enc_r(r_ops[k][9:3], 5'd2, 5'd1, r_ops[k][2:0], 5'd3));
        set_reg(5'd3, r_ref(r_ops[k][9:3], r_ops[k][2:0], model[1], model[2]));
        store_reg(5'd3);
      end
      rnd = lfsr_bits(12);
      emit(enc_i(rnd[11:0], 5'd1, 3'b000, 5'd4, 7'h13));
      set_reg(5'd4, model[1] + sext12(rnd[11:0]));
      store_reg(5'd4);
    end
    // auipc adds the upper immediate to its own pc
    pc_jump = prog_pc;
    rnd = lfsr_bits(20);
    emit(enc_u(rnd[19:0], 5'd6, 7'h17));
    set_reg(5'd6, pc_jump + {rnd[19:0], 12'h000});
    store_reg(5'd6);
    // writes to x0 are dropped
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    emit(enc_i(12'h155, 5'd1, 3'b000, 5'd0, 7'h13));
    store_reg(5'd0);
    // reload the sub result and store it again
    emit(enc_i(12'd4, 5'd10, 3'b010, 5'd7, 7'h03));
    set_reg(5'd7, exp_data[model[10] + 32'd4]);
    store_reg(5'd7);
    // jal over one marker
    pc_jump = prog_pc;
    emit(enc_j(21'd8, 5'd8));
    set_reg(5'd8, pc_jump + 32'd4);
    emit(marker);
    store_reg(5'd8);
    // jalr with an odd offset drops bit 0 of the target
    pc_jump = prog_pc;
    emit(enc_u(20'h00000, 5'd9, 7'h17));
    set_reg(5'd9, pc_jump);
    emit(enc_i(12'd13, 5'd9, 3'b000, 5'd11, 7'h67));
    set_reg(5'd11, pc_jump + 32'd8);
    emit(marker);
    store_reg(5'd9);
    store_reg(5'd11);
    branch_case(3'b000, 5'd1, 5'd1);
    branch_case(3'b000, 5'd1, 5'd2);
    branch_case(3'b001, 5'd1, 5'd1);
    branch_case(3'b001, 5'd1, 5'd2);
    emit(32'h0010_0073);
  endfunction

  function automatic void build_illegal();
    logic [31:0] rnd;
    rnd = lfsr_bits(12);
    emit(enc_i(rnd[11:0], 5'd0, 3'b000, 5'd1, 7'h13));
    set_reg(5'd1, sext12(rnd[11:0]));
    store_reg(5'd1);
    // mul is outside the kept set
    emit(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(marker);
  endfunction

  function automatic int count_missing();
    int n;
    n = 0;
    foreach (exp_data[a]) begin
      if (!seen.exists(a)) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic enter_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
  endtask

  task automatic leave_reset();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_stop(input bit want_illegal, input int max_cycles);
    int n;
    n = 0;
    while ((want_illegal ? illegal : halted) !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > max_cycles) begin
        report_failure($sformatf("timeout, core did not stop within %0d cycles",
                                 max_cycles));
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    lfsr_state = 32'h7a42;
    missing = 0;
    // memories hold defined words from time zero
    clear_state();
    build_main();
    enter_reset();
    leave_reset();
    wait_stop(1'b0, 200);
    // a few edges with the core frozen
    repeat (4) @(negedge clk);
    missing = missing + count_missing();
    // second run ends on an illegal word
    enter_reset();
    clear_state();
    build_illegal();
    leave_reset();
    wait_stop(1'b1, 50);
    repeat (4) @(negedge clk);
    assert (halted === 1'b0) else report_failure("halted rose on an illegal word");
    missing = missing + count_missing();
    if (missing != 0) begin
      report_failure($sformatf("%0d expected stores never happened", missing));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- rv_core.f
rv_core_pkg.sv
inst_decoder.sv
reg_file.sv
exec_unit.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv
